// File: files.f
verilog/hififo_pkg.sv
verilog/fifo_pkg.sv
verilog/host_link_ctrl.sv
verilog/word_fifo.sv
verilog/loopback_app.sv
verilog/tx_framer.sv
verilog/hififo_top.sv
tb/hififo_checker.sv
tb/tb_hififo.sv

// File: tb/hififo_checker.sv
//**********************************************************
// Monitor of the FIFO bridge that models the expected words
// and compares completions, interrupt, LEDs and error flag
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module hififo_checker
  (
   input  wire                      clock,
   input  wire                      arst_n,
   input  wire                      rx_valid,
   input  wire                      rx_last,
   input  wire hififo_pkg::word_t   rx_data,
   input  wire hififo_pkg::bus_id_t bus_id,
   input  wire                      tx_valid,
   input  wire                      tx_ready,
   input  wire hififo_pkg::word_t   tx_data,
   input  wire                      tx_last,
   input  wire                      interrupt,
   input  wire                      rx_error,
   input  wire hififo_pkg::led_t    led,
   input  wire                      check_strobe,
   output int                       error_count,
   output int                       cpl_count
   );

   import hififo_pkg::*;
   import fifo_pkg::*;

   // Words written by the host and not yet returned, oldest first
   word_t written [$];
   // Lengths of read requests still waiting for their completion
   len_t  reads [$];

   logic  in_pkt;
   logic  in_write;
   logic  in_cpl;
   logic  err_exp;
   logic  overflowed;
   logic  int_next;
   logic  stalled;
   len_t  remaining;
   word_t held_data;
   word_t exp_word;
   led_t  led_exp;

   task automatic report_mismatch(input string name, input logic [63:0] expected,
                                  input logic [63:0] actual);
      begin
         $display("MISMATCH %s at %0t: expected 0x%0h got 0x%0h", name, $time, expected, actual);
         error_count++;
      end
   endtask

   task automatic report_failure(input string what);
      begin
         $display("ERROR at %0t: %s", $time, what);
         error_count++;
      end
   endtask

   //**********************************************************
   // Inbound packets build the expected data and error state
   //**********************************************************
   task track_inbound();
      begin
         if (rx_valid)
         begin
            if (!in_pkt)
            begin
               // Header word decides what the rest of the packet is
               if (rx_data[63:56] == OP_READ)
                  reads.push_back(rx_data[15:0]);
               else if (rx_data[63:56] != OP_WRITE)
                  err_exp = 1'b1;
               in_write = (rx_data[63:56] == OP_WRITE);
            end
            else if (in_write)
            begin
               written.push_back(rx_data);
               // Both FIFOs together cannot hold this many words
               if (written.size() > 2 * FIFO_DEPTH - 2)
                  overflowed = 1'b1;
               if (written.size() > 2 * FIFO_DEPTH + 2)
                  err_exp = 1'b1;
               if (!overflowed)
                  led_exp = rx_data[3:0];
            end
            in_pkt = !rx_last;
         end
      end
   endtask

   // One accepted outbound word, either a header or a data word
   task take_word();
      begin
         if (!in_cpl)
         begin
            if (reads.size() == 0)
            begin
               report_failure("outbound word seen with no read request pending");
            end
            else
            begin
               remaining = reads.pop_front();
               if (tx_data[63:56] !== OP_COMPLETION)
                  report_mismatch("tx_data opcode", OP_COMPLETION, tx_data[63:56]);
               if (tx_data[31:16] !== bus_id)
                  report_mismatch("tx_data bus_id", bus_id, tx_data[31:16]);
               if (tx_data[15:0] !== remaining)
                  report_mismatch("tx_data length", remaining, tx_data[15:0]);
               in_cpl = (remaining != '0);
               cpl_count++;
               if (tx_last !== !in_cpl)
                  report_mismatch("tx_last", !in_cpl, tx_last);
            end
         end
         else
         begin
            if (written.size() == 0)
            begin
               report_failure("completion carries more words than the host wrote");
            end
            else
            begin
               exp_word = written.pop_front();
               if (tx_data !== exp_word)
                  report_mismatch("tx_data", exp_word, tx_data);
            end
            remaining = remaining - 1'b1;
            in_cpl = (remaining != '0);
            if (tx_last !== !in_cpl)
               report_mismatch("tx_last", !in_cpl, tx_last);
         end
      end
   endtask

   // Outputs are sampled on the falling edge where they are stable
   always @(negedge clock)
   begin
      if (!arst_n)
      begin
         written.delete();
         reads.delete();
         in_pkt     = 1'b0;
         in_write   = 1'b0;
         in_cpl     = 1'b0;
         err_exp    = 1'b0;
         overflowed = 1'b0;
         int_next   = 1'b0;
         stalled    = 1'b0;
         led_exp    = LED_RESET;
      end
      else
      begin
         track_inbound();
         // Interrupt follows a tx_last transfer by exactly one cycle
         if (interrupt !== int_next)
            report_mismatch("interrupt", int_next, interrupt);
         if (stalled && tx_valid !== 1'b1)
            report_mismatch("tx_valid", 1'b1, tx_valid);
         if (stalled && tx_data !== held_data)
            report_mismatch("tx_data", held_data, tx_data);
         int_next  = tx_valid && tx_ready && tx_last;
         stalled   = tx_valid && !tx_ready;
         held_data = tx_data;
         if (tx_valid && tx_ready)
            take_word();
         if (check_strobe)
         begin
            if (rx_error !== err_exp)
               report_mismatch("rx_error", err_exp, rx_error);
            // Dropped words leave the LED value undefined for the model
            if (!overflowed && led !== led_exp)
               report_mismatch("led", led_exp, led);
         end
      end
   end

   initial
   begin
      error_count = 0;
      cpl_count   = 0;
   end

endmodule

`default_nettype wire

// File: tb/tb_hififo.sv
//**********************************************************
// Testbench of the FIFO bridge that plays a table of host
// packets and waits for each completion
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_hififo;

   import hififo_pkg::*;
   import fifo_pkg::*;

   localparam int      NUM_ROWS      = 11;
   localparam int      CPL_TIMEOUT   = 2000;
   // Long enough for a write to pass both FIFOs and the loopback
   localparam int      SETTLE_CYCLES = 16;
   localparam opcode_t OP_BOGUS      = 8'h7E;
   localparam bus_id_t CARD_ID       = 16'hB1D5;

   // One table row is one host packet
   typedef struct packed
   {
      opcode_t op;
      len_t    len;
      word_t   base;
      logic    stall;
   } row_t;

   logic       clock;
   logic       arst_n;
   logic       rx_valid;
   logic       rx_last;
   word_t      rx_data;
   bus_id_t    bus_id;
   logic       tx_ready;
   logic       stall_en;
   logic       check_strobe;
   wire        tx_valid;
   wire word_t tx_data;
   wire        tx_last;
   wire        interrupt;
   wire        rx_error;
   wire led_t  led;
   int         error_count;
   int         cpl_count;
   int         timeouts;
   integer     seed;
   row_t       rows [NUM_ROWS];

   hififo_top dut_i
     (.clock(clock), .arst_n(arst_n),
      .rx_valid(rx_valid), .rx_last(rx_last), .rx_data(rx_data),
      .bus_id(bus_id), .tx_ready(tx_ready),
      .tx_valid(tx_valid), .tx_data(tx_data), .tx_last(tx_last),
      .interrupt(interrupt), .rx_error(rx_error), .led(led));

   hififo_checker checker_i
     (.clock(clock), .arst_n(arst_n),
      .rx_valid(rx_valid), .rx_last(rx_last), .rx_data(rx_data), .bus_id(bus_id),
      .tx_valid(tx_valid), .tx_ready(tx_ready), .tx_data(tx_data), .tx_last(tx_last),
      .interrupt(interrupt), .rx_error(rx_error), .led(led),
      .check_strobe(check_strobe), .error_count(error_count), .cpl_count(cpl_count));

   initial
   begin
      clock = 1'b0;
      forever #5 clock = ~clock;
   end

   // Host side back-pressure, random only on rows that ask for it
   always @(posedge clock)
   begin
      #1;
      if (stall_en)
         tx_ready = (($random(seed) & 3) != 0);
      else
         tx_ready = 1'b1;
   end

   function automatic row_t make_row(input opcode_t op, input int len,
                                     input word_t base, input logic stall);
      row_t r;
      begin
         r.op    = op;
         r.len   = len_t'(len);
         r.base  = base;
         r.stall = stall;
         return r;
      end
   endfunction

   task automatic drive_word(input word_t data, input logic last);
      begin
         @(posedge clock);
         #1;
         rx_valid = 1'b1;
         rx_data  = data;
         rx_last  = last;
      end
   endtask

   // Hold the bridge in reset for five cycles between two packets
   task automatic reset_dut();
      begin
         @(posedge clock);
         #1;
         arst_n = 1'b0;
         repeat (5) @(posedge clock);
         #1;
         arst_n = 1'b1;
      end
   endtask

   //**********************************************************
   // Packet stimulus and waits
   //**********************************************************
   task automatic send_packet(input row_t row);
      int i;
      begin
         // A read request is a lone header, other kinds carry len words
         drive_word({row.op, 40'h0, row.len}, row.op == OP_READ || row.len == '0);
         if (row.op != OP_READ)
         begin
            for (i = 0; i < row.len; i++)
               drive_word(row.base + i, i == row.len - 1);
         end
         @(posedge clock);
         #1;
         rx_valid = 1'b0;
         rx_last  = 1'b0;
      end
   endtask

   task automatic wait_completion(input int row);
      int   cycles;
      logic seen;
      begin
         seen   = 1'b0;
         cycles = 0;
         while (!seen && cycles < CPL_TIMEOUT)
         begin
            @(negedge clock);
            seen = interrupt;
            cycles++;
         end
         if (!seen)
         begin
            $display("Timeout: row %0d got no completion within %0d cycles", row, CPL_TIMEOUT);
            timeouts++;
         end
      end
   endtask

   // Ask the checker to compare led and rx_error on one cycle
   task automatic pulse_check();
      begin
         @(posedge clock);
         #1;
         check_strobe = 1'b1;
         @(posedge clock);
         #1;
         check_strobe = 1'b0;
      end
   endtask

   initial
   begin
      int r;
      seed         = 51915;
      timeouts     = 0;
      arst_n       = 1'b0;
      rx_valid     = 1'b0;
      rx_last      = 1'b0;
      rx_data      = '0;
      bus_id       = CARD_ID;
      tx_ready     = 1'b1;
      stall_en     = 1'b0;
      check_strobe = 1'b0;

      rows[0]  = make_row(OP_WRITE, 4, 64'h0123_4567_89AB_C000, 1'b0);
      rows[1]  = make_row(OP_READ, 4, '0, 1'b0);
      rows[2]  = make_row(OP_WRITE, 12, 64'hFEED_0000_0000_0101, 1'b0);
      rows[3]  = make_row(OP_READ, 12, '0, 1'b1);
      rows[4]  = make_row(OP_READ, 0, '0, 1'b1);
      rows[5]  = make_row(OP_WRITE, 5, 64'hA5A5_0000_0000_0F03, 1'b0);
      rows[6]  = make_row(OP_READ, 3, '0, 1'b1);
      rows[7]  = make_row(OP_READ, 2, '0, 1'b0);
      rows[8]  = make_row(OP_BOGUS, 3, 64'hDEAD_0000_0000_0000, 1'b0);
      // Overflow both FIFOs, then read back a prefix of the words
      rows[9]  = make_row(OP_WRITE, 3 * FIFO_DEPTH, 64'hC0DE_0000_0000_0007, 1'b0);
      rows[10] = make_row(OP_READ, FIFO_DEPTH, '0, 1'b1);

      repeat (5) @(posedge clock);
      #1;
      arst_n = 1'b1;
      pulse_check();

      for (r = 0; r < NUM_ROWS && timeouts == 0; r++)
      begin
         // The overflow write starts from reset so that rx_error can only come from dropped words
         if (rows[r].op == OP_WRITE && rows[r].len > 2 * FIFO_DEPTH)
            reset_dut();
         stall_en = rows[r].stall;
         send_packet(rows[r]);
         if (rows[r].op == OP_READ)
            wait_completion(r);
         repeat (SETTLE_CYCLES) @(posedge clock);
         pulse_check();
      end

      $display("Summary: %0d mismatches, %0d timeouts, %0d completions",
               error_count, timeouts, cpl_count);
      if (error_count == 0 && timeouts == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog/fifo_pkg.sv
//**********************************************************
// FIFO sizing shared by both word FIFOs of the bridge
//**********************************************************
`default_nettype none

package fifo_pkg;

   // Number of 64-bit entries in each FIFO
   localparam int FIFO_DEPTH = 16;

   // Read and write pointer width
   localparam int FIFO_AW = $clog2(FIFO_DEPTH);

   // Fill count needs one extra bit to tell full from empty
   typedef logic [FIFO_AW:0] count_t;

endpackage

`default_nettype wire

// File: verilog/hififo_pkg.sv
//**********************************************************
// Host link package with packet words, header fields, opcodes,
// LED reset value and the state encodings of the link FSMs
//**********************************************************
`default_nettype none

package hififo_pkg;

   // One word on the host link in either direction
   typedef logic [63:0] word_t;

   // Packet kind carried in header bits 63 to 56
   typedef logic [7:0] opcode_t;

   // Word count carried in header bits 15 to 0
   typedef logic [15:0] len_t;

   // Bus id of the card as stamped into completion bits 31 to 16
   typedef logic [15:0] bus_id_t;

   // Front panel LEDs
   typedef logic [3:0] led_t;

   //**********************************************************
   // Opcodes and reset values
   //**********************************************************
   localparam opcode_t OP_WRITE      = 8'h01;
   localparam opcode_t OP_READ       = 8'h02;
   localparam opcode_t OP_COMPLETION = 8'h03;

   // Pattern shown on the LEDs until the first word arrives
   localparam led_t LED_RESET = 4'h5;

   // Inbound packet parser states
   typedef enum logic [1:0] {CTRL_IDLE, CTRL_WRITE_DATA, CTRL_DISCARD} ctrl_state_t;

   // Completion framer states
   typedef enum logic [1:0] {FR_IDLE, FR_HEADER, FR_DATA} framer_state_t;

endpackage

`default_nettype wire

// File: verilog/hififo_top.sv
//**********************************************************
// Host-to-card FIFO bridge with loopback of written words
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module hififo_top
  (
   input  wire                      clock,
   input  wire                      arst_n,
   input  wire                      rx_valid,
   input  wire                      rx_last,
   input  wire hififo_pkg::word_t   rx_data,
   input  wire hififo_pkg::bus_id_t bus_id,
   input  wire                      tx_ready,
   output wire                      tx_valid,
   output wire hififo_pkg::word_t   tx_data,
   output wire                      tx_last,
   output wire                      interrupt,
   output wire                      rx_error,
   output wire hififo_pkg::led_t    led
   );

   import hififo_pkg::*;

   // From-host path
   wire   fpc_write;
   word_t fpc_wdata;
   wire   fpc_full;
   wire   fpc_valid;
   word_t fpc_data;
   wire   fpc_read;

   // To-host path
   wire   tpc_write;
   word_t tpc_wdata;
   wire   tpc_ready;
   wire   tpc_valid;
   word_t tpc_rdata;
   wire   tpc_read;

   // Completion request
   wire   cpl_start;
   len_t  cpl_len;
   wire   cpl_busy;

   host_link_ctrl host_link_ctrl_i
     (.clock(clock), .arst_n(arst_n),
      .rx_valid(rx_valid), .rx_last(rx_last), .rx_data(rx_data),
      .fpc_full(fpc_full), .cpl_busy(cpl_busy),
      .fpc_write(fpc_write), .fpc_wdata(fpc_wdata),
      .cpl_start(cpl_start), .cpl_len(cpl_len), .rx_error(rx_error));

   word_fifo fpc_fifo_i
     (.clock(clock), .arst_n(arst_n),
      .write(fpc_write), .wdata(fpc_wdata), .read(fpc_read),
      .full(fpc_full), .ready(), .valid(fpc_valid), .rdata(fpc_data), .count());

   loopback_app loopback_app_i
     (.clock(clock), .arst_n(arst_n),
      .fpc_valid(fpc_valid), .fpc_data(fpc_data), .tpc_ready(tpc_ready),
      .fpc_read(fpc_read), .tpc_write(tpc_write), .tpc_data(tpc_wdata), .led(led));

   word_fifo tpc_fifo_i
     (.clock(clock), .arst_n(arst_n),
      .write(tpc_write), .wdata(tpc_wdata), .read(tpc_read),
      .full(), .ready(tpc_ready), .valid(tpc_valid), .rdata(tpc_rdata), .count());

   tx_framer tx_framer_i
     (.clock(clock), .arst_n(arst_n),
      .cpl_start(cpl_start), .cpl_len(cpl_len), .bus_id(bus_id),
      .tpc_valid(tpc_valid), .tpc_data(tpc_rdata), .tx_ready(tx_ready),
      .cpl_busy(cpl_busy), .tpc_read(tpc_read),
      .tx_valid(tx_valid), .tx_data(tx_data), .tx_last(tx_last),
      .interrupt(interrupt));

endmodule

`default_nettype wire

// File: verilog/host_link_ctrl.sv
//**********************************************************
// Inbound packet parser that feeds the from-host FIFO and
// starts completions for read requests
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module host_link_ctrl
  (
   input  wire                clock,
   input  wire                arst_n,
   input  wire                rx_valid,
   input  wire                rx_last,
   input  wire hififo_pkg::word_t rx_data,
   input  wire                fpc_full,
   input  wire                cpl_busy,
   output logic               fpc_write,
   output hififo_pkg::word_t  fpc_wdata,
   output logic               cpl_start,
   output hififo_pkg::len_t   cpl_len,
   output logic               rx_error
   );

   import hififo_pkg::*;

   ctrl_state_t state;

   // A data word captured last cycle and waiting to enter the FIFO
   logic    wr_pend;

   // Opcode field of the word on the link, only meaningful on a header
   opcode_t rx_op;

   assign rx_op = rx_data[63:56];

   // The link has no back-pressure so a word meeting a full FIFO is lost
   assign fpc_write = wr_pend && !fpc_full;

   //**********************************************************
   // Packet parser
   //**********************************************************
   always_ff @(posedge clock or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state     <= CTRL_IDLE;
         wr_pend   <= 1'b0;
         cpl_start <= 1'b0;
         rx_error  <= 1'b0;
      end
      else
      begin
         wr_pend   <= 1'b0;
         cpl_start <= 1'b0;

         // Error is sticky until reset
         if (wr_pend && fpc_full)
         begin
            rx_error <= 1'b1;
         end

         if (rx_valid)
         begin
            case (state)
               CTRL_IDLE:
               begin
                  // First word of every packet is its header
                  case (rx_op)
                     OP_WRITE:
                     begin
                        if (!rx_last)
                        begin
                           state <= CTRL_WRITE_DATA;
                        end
                     end
                     OP_READ:
                     begin
                        // A start still in flight counts as busy since the
                        // framer raises cpl_busy one cycle later
                        if (cpl_busy || cpl_start)
                        begin
                           rx_error <= 1'b1;
                        end
                        else
                        begin
                           cpl_start <= 1'b1;
                        end
                        if (!rx_last)
                        begin
                           state <= CTRL_DISCARD;
                        end
                     end
                     default:
                     begin
                        rx_error <= 1'b1;
                        if (!rx_last)
                        begin
                           state <= CTRL_DISCARD;
                        end
                     end
                  endcase
               end
               CTRL_WRITE_DATA:
               begin
                  wr_pend <= 1'b1;
                  if (rx_last)
                  begin
                     state <= CTRL_IDLE;
                  end
               end
               default:
               begin
                  // Skip the rest of a packet we do not understand
                  if (rx_last)
                  begin
                     state <= CTRL_IDLE;
                  end
               end
            endcase
         end
      end
   end

   // Data word and read length follow the link one cycle later
   always_ff @(posedge clock)
   begin
      if (rx_valid)
      begin
         fpc_wdata <= rx_data;
         cpl_len   <= rx_data[15:0];
      end
   end

   // The framer never sees a second start while it is still sending
   a_start_idle: assert property (@(posedge clock) disable iff (!arst_n)
                                  cpl_start |-> !cpl_busy);

endmodule

`default_nettype wire

// File: verilog/loopback_app.sv
//**********************************************************
// Echo engine from the from-host FIFO to the to-host FIFO
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module loopback_app
  (
   input  wire                    clock,
   input  wire                    arst_n,
   input  wire                    fpc_valid,
   input  wire hififo_pkg::word_t fpc_data,
   input  wire                    tpc_ready,
   output logic                   fpc_read,
   output logic                   tpc_write,
   output hififo_pkg::word_t      tpc_data,
   output hififo_pkg::led_t       led
   );

   import hififo_pkg::*;

   always_ff @(posedge clock or negedge arst_n)
   begin
      if (!arst_n)
      begin
         fpc_read  <= 1'b0;
         tpc_write <= 1'b0;
         led       <= LED_RESET;
      end
      else
      begin
         // LEDs follow the low nibble of whatever sits at the head
         if (fpc_valid)
         begin
            led <= fpc_data[3:0];
         end
         // Pull only while the to-host side has room
         fpc_read  <= tpc_ready;
         // A word popped this cycle is written on the next one
         tpc_write <= fpc_valid && fpc_read;
      end
   end

   always_ff @(posedge clock)
   begin
      tpc_data <= fpc_data;
   end

endmodule

`default_nettype wire

// File: verilog/tx_framer.sv
//**********************************************************
// Completion framer that sends a header then len words from
// the to-host FIFO and pulses the interrupt at the end
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module tx_framer
  (
   input  wire                      clock,
   input  wire                      arst_n,
   input  wire                      cpl_start,
   input  wire hififo_pkg::len_t    cpl_len,
   input  wire hififo_pkg::bus_id_t bus_id,
   input  wire                      tpc_valid,
   input  wire hififo_pkg::word_t   tpc_data,
   input  wire                      tx_ready,
   output logic                     cpl_busy,
   output logic                     tpc_read,
   output logic                     tx_valid,
   output hififo_pkg::word_t        tx_data,
   output logic                     tx_last,
   output logic                     interrupt
   );

   import hififo_pkg::*;

   framer_state_t state;

   // Data words not yet fetched from the to-host FIFO
   len_t  remaining;
   word_t header;
   logic  tx_fire;
   logic  tpc_pop;

   assign header  = {OP_COMPLETION, 24'h000000, bus_id, cpl_len};
   assign tx_fire = tx_valid && tx_ready;

   // Fetch while words are owed and the output register frees up
   assign tpc_read = (state != FR_IDLE) && (remaining != '0) && (!tx_valid || tx_ready);
   assign tpc_pop  = tpc_read && tpc_valid;

   //**********************************************************
   // Framing FSM
   //**********************************************************
   always_ff @(posedge clock or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state     <= FR_IDLE;
         remaining <= '0;
         cpl_busy  <= 1'b0;
         tx_valid  <= 1'b0;
         tx_last   <= 1'b0;
         interrupt <= 1'b0;
      end
      else
      begin
         interrupt <= 1'b0;
         if (state == FR_IDLE)
         begin
            if (cpl_start)
            begin
               state     <= FR_HEADER;
               remaining <= cpl_len;
               cpl_busy  <= 1'b1;
               tx_valid  <= 1'b1;
               // A zero length read is a header-only completion
               tx_last   <= (cpl_len == '0);
            end
         end
         else if (tx_fire && tx_last)
         begin
            state     <= FR_IDLE;
            cpl_busy  <= 1'b0;
            tx_valid  <= 1'b0;
            tx_last   <= 1'b0;
            interrupt <= 1'b1;
         end
         else
         begin
            if (tx_fire && state == FR_HEADER)
            begin
               state <= FR_DATA;
            end
            if (tpc_pop)
            begin
               tx_valid  <= 1'b1;
               tx_last   <= (remaining == len_t'(1));
               remaining <= remaining - 1'b1;
            end
            else if (tx_fire)
            begin
               tx_valid <= 1'b0;
            end
         end
      end
   end

   // Output word only changes when the register is empty or draining
   always_ff @(posedge clock)
   begin
      if (state == FR_IDLE && cpl_start)
      begin
         tx_data <= header;
      end
      else if (tpc_pop)
      begin
         tx_data <= tpc_data;
      end
   end

   // A stalled word stays offered and unchanged on the next cycle
   a_tx_hold: assert property (@(posedge clock) disable iff (!arst_n)
                               (tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_data)));

endmodule

`default_nettype wire

// File: verilog/word_fifo.sv
//**********************************************************
// Synchronous first-word-fall-through FIFO of link words
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module word_fifo
  (
   input  wire                    clock,
   input  wire                    arst_n,
   input  wire                    write,
   input  wire hififo_pkg::word_t wdata,
   input  wire                    read,
   output logic                   full,
   output logic                   ready,
   output logic                   valid,
   output hififo_pkg::word_t      rdata,
   output fifo_pkg::count_t       count
   );

   import hififo_pkg::*;
   import fifo_pkg::*;

   // Storage is a plain register array
   word_t              mem [FIFO_DEPTH];
   logic [FIFO_AW-1:0] wr_ptr;
   logic [FIFO_AW-1:0] rd_ptr;
   logic               push;
   logic               pop;

   assign push = write && !full;
   assign pop  = read && valid;

   assign full  = (count == count_t'(FIFO_DEPTH));
   assign valid = (count != '0);

   // Head word is always on the output
   assign rdata = mem[rd_ptr];

   // Two free slots still left after the write already under way
   // This covers the registered read and write of the producer
   assign ready = (count + count_t'(write)) <= count_t'(FIFO_DEPTH - 2);

   //**********************************************************
   // Pointers and fill count
   //**********************************************************
   always_ff @(posedge clock or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         // Pointers wrap naturally since the depth is a power of two
         if (push)
         begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop)
         begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clock)
   begin
      if (push)
      begin
         mem[wr_ptr] <= wdata;
      end
   end

   // The producer respects full so no word is ever dropped here
   a_no_overflow: assert property (@(posedge clock) disable iff (!arst_n)
                                   write |-> !full);

endmodule

`default_nettype wire
